// ==== Makefile ====
# Verilator build and run of the modred testbench

VERILATOR ?= verilator
TOP       ?= modred_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/modred_properties.sv ====
`timescale 1ns/1ns
`include "modred_params.svh"

module modred_properties (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic [`MR_NUM_REQ-1:0] req_i,
  input logic [`MR_NUM_REQ-1:0] we_i,
  input logic [`MR_NUM_REQ-1:0] gnt_i,
  input logic [`MR_NUM_REQ-1:0] rvalid_i
);

  // ==========================================================
  // grant shape
  // ==========================================================
  gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt_i))
    else $error("arbiter granted more than one requester");

  gnt_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (gnt_i & ~req_i) == '0)
    else $error("grant given to a requester without a request");

  rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i == $past(gnt_i & ~we_i))
    else $error("rvalid does not follow a read grant by one cycle");

  // held request waits at most two grants
  for (genvar r = 0; r < `MR_NUM_REQ; r++) begin : g_fair
    held_req_granted: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (req_i[r] && $past(req_i[r] && !gnt_i[r]) && $past(req_i[r] && !gnt_i[r], 2))
      |-> gnt_i[r])
      else $error("requester %0d not granted within three cycles", r);
  end

endmodule

bind modred_shared_mem modred_properties u_props (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .req_i    (req_i),
  .we_i     (we_i),
  .gnt_i    (gnt_o),
  .rvalid_i (rvalid_o)
);

// ==== bench/modred_tb.sv ====
`timescale 1ns/1ns
`include "modred_params.svh"

module modred_tb;
  import modred_pkg::*;

  localparam int          HALF_PERIOD = 20;
  localparam logic [31:0] LFSR_SEED   = 32'd70115;
  localparam int          APB_TIMEOUT = 32;    // cycles per access
  localparam int          POLL_LIMIT  = 4000;  // status reads per job
  localparam logic [11:0] OFS_CFG     = 12'h0;
  localparam logic [11:0] OFS_BASE    = 12'h4;
  localparam logic [11:0] OFS_COUNT   = 12'h8;
  localparam logic [11:0] OFS_CTRL    = 12'hC;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  word_t       pwdata;
  word_t       prdata;
  logic        pready;
  logic        pslverr;
  logic [31:0] lfsr_q;
  word_t       shadow [`MR_MEM_DEPTH];  // expected memory contents

  modred_top UUT (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  always #HALF_PERIOD clk = ~clk;

  // ==========================================================
  // random source and reference model
  // ==========================================================
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  function automatic word_t rand_bits(input int nbits);
    word_t v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic longint unsigned modulus(input int k, input mod_kind_e kind);
    return (kind == MOD_FERMAT) ? (64'd1 << k) + 64'd1 : (64'd1 << k) - 64'd1;
  endfunction

  function automatic word_t ref_mod(input word_t x, input int k, input mod_kind_e kind);
    longint unsigned xv;
    xv = 64'(x);
    return word_t'(xv % modulus(k, kind));
  endfunction

  function automatic logic [11:0] reg_addr(input int eng, input logic [11:0] ofs);
    return 12'(`MR_REG_BASE + eng * `MR_ENG_STRIDE) + ofs;
  endfunction

  // ==========================================================
  // checks
  // ==========================================================
  task automatic end_with_failure;
    $display("Test FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_status(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      $display("ERROR %s expected done/busy %b actual %b", name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_slverr(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s expected pslverr %b actual %b", name, exp, act);
      end_with_failure();
    end
  endtask

  // ==========================================================
  // apb access
  // ==========================================================
  task automatic apb_access(input logic wr, input logic [11:0] addr, input word_t wdata,
                            output word_t rdata, output logic err);
    int cyc;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    cyc = 0;
    @(posedge clk);
    while (!pready && cyc < APB_TIMEOUT) begin
      @(posedge clk);
      cyc++;
    end
    if (!pready) begin
      $display("timeout: no pready for APB access to address %h", addr);
      end_with_failure();
    end else begin
      rdata = prdata;
      err   = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  task automatic apb_write(input logic [11:0] addr, input word_t data, output logic err);
    word_t unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [11:0] addr, output word_t data, output logic err);
    apb_access(1'b0, addr, '0, data, err);
  endtask

  task automatic reg_write(input string name, input logic [11:0] addr, input word_t data);
    logic err;
    apb_write(addr, data, err);
    check_slverr(name, 1'b0, err);
  endtask

  task automatic reg_read(input string name, input logic [11:0] addr, output word_t data);
    logic err;
    apb_read(addr, data, err);
    check_slverr(name, 1'b0, err);
  endtask

  // ==========================================================
  // memory and engine helpers
  // ==========================================================
  task automatic mem_put(input int idx, input word_t data);
    reg_write("memory write", 12'(idx * 4), data);
    shadow[idx] = data;
  endtask

  task automatic fill_random(input int lo, input int hi);
    for (int i = lo; i <= hi; i++) begin
      mem_put(i, rand_bits(32));
    end
  endtask

  task automatic check_range(input string name, input int lo, input int hi);
    word_t rd;
    for (int i = lo; i <= hi; i++) begin
      reg_read(name, 12'(i * 4), rd);
      check_word(name, shadow[i], rd);
    end
  endtask

  task automatic load_edge(input int base, input int k, input mod_kind_e kind);
    longint unsigned m;
    m = modulus(k, kind);
    mem_put(base, '0);
    mem_put(base + 1, word_t'(m));
    mem_put(base + 2, word_t'(m - 64'd1));
    mem_put(base + 3, 32'hFFFF_FFFF);
    mem_put(base + 4, word_t'(m + 64'd1));
    mem_put(base + 5, word_t'(2 * m));
    mem_put(base + 6, 32'd1);
    mem_put(base + 7, rand_bits(32));
  endtask

  task automatic apply_model(input int base, input int count, input int k,
                             input mod_kind_e kind);
    for (int i = base; i < base + count; i++) begin
      shadow[i] = ref_mod(shadow[i], k, kind);
    end
  endtask

  task automatic configure(input int eng, input int base, input int count, input int k,
                           input mod_kind_e kind);
    reg_write("cfg write", reg_addr(eng, OFS_CFG),
              word_t'(k) | ((kind == MOD_FERMAT) ? 32'h100 : 32'h0));
    reg_write("base write", reg_addr(eng, OFS_BASE), word_t'(base));
    reg_write("count write", reg_addr(eng, OFS_COUNT), word_t'(count));
  endtask

  task automatic wait_idle(input int eng);
    word_t st;
    int    polls;
    polls = 0;
    reg_read("ctrl poll", reg_addr(eng, OFS_CTRL), st);
    while (st[0] && polls < POLL_LIMIT) begin
      reg_read("ctrl poll", reg_addr(eng, OFS_CTRL), st);
      polls++;
    end
    if (st[0]) begin
      $display("timeout: engine %0d still busy after %0d status reads", eng, polls);
      end_with_failure();
    end
  endtask

  task automatic run_job(input string name, input int eng, input int base, input int count,
                         input int k, input mod_kind_e kind);
    word_t st;
    configure(eng, base, count, k, kind);
    reg_write(name, reg_addr(eng, OFS_CTRL), 32'd1);
    wait_idle(eng);
    reg_read(name, reg_addr(eng, OFS_CTRL), st);
    check_status(name, 2'b10, st[1:0]);
    apply_model(base, count, k, kind);
    check_range(name, base - 2, base + count + 1);  // neighbours stay unchanged
  endtask

  // ==========================================================
  // test sequence
  // ==========================================================
  initial begin
    word_t     rd;
    word_t     st0;
    word_t     st1;
    word_t     cfg_before;
    logic      err;
    int        k0;
    int        k1;
    int        idx;
    int        polls;
    mod_kind_e kind;

    clk       = 1'b0;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    lfsr_q    = LFSR_SEED;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    check_slverr("reset pslverr", 1'b0, pslverr);
    for (int e = 0; e < 2; e++) begin
      for (int r = 0; r < 4; r++) begin
        reg_read("reset regs", reg_addr(e, 12'(r * 4)), rd);
        check_word("reset regs", '0, rd);
      end
    end

    // memory window
    fill_random(0, `MR_MEM_DEPTH - 1);
    for (int i = 0; i < 8; i++) begin
      idx = int'(rand_bits(8));
      mem_put(idx, rand_bits(32));
    end
    check_range("memory window", 0, `MR_MEM_DEPTH - 1);

    // single engine batches
    for (int r = 0; r < 2; r++) begin
      k0 = 2 + int'(rand_bits(8) % 15);
      fill_random(30, 57);
      run_job("mersenne batch", 0, 32, 24, k0, MOD_MERSENNE);
      k1 = 2 + int'(rand_bits(8) % 15);
      fill_random(78, 105);
      run_job("fermat batch", 1, 80, 24, k1, MOD_FERMAT);
    end

    // both engines while the window is read
    k0 = 2 + int'(rand_bits(8) % 15);
    k1 = 2 + int'(rand_bits(8) % 15);
    fill_random(128, 159);
    fill_random(188, 221);
    configure(0, 130, 28, k0, MOD_MERSENNE);
    configure(1, 190, 30, k1, MOD_FERMAT);
    reg_write("concurrency start", reg_addr(0, OFS_CTRL), 32'd1);
    reg_write("concurrency start", reg_addr(1, OFS_CTRL), 32'd1);
    polls = 0;
    do begin
      reg_read("concurrency poll", reg_addr(0, OFS_CTRL), st0);
      reg_read("concurrency poll", reg_addr(1, OFS_CTRL), st1);
      reg_read("concurrency window", 12'((polls % 16) * 4), rd);
      check_word("concurrency window", shadow[polls % 16], rd);
      polls++;
    end while ((st0[0] || st1[0]) && polls < POLL_LIMIT);
    if (st0[0] || st1[0]) begin
      $display("timeout: engines still busy in the concurrent run");
      end_with_failure();
    end
    check_status("concurrency eng0", 2'b10, st0[1:0]);
    check_status("concurrency eng1", 2'b10, st1[1:0]);
    apply_model(130, 28, k0, MOD_MERSENNE);
    apply_model(190, 30, k1, MOD_FERMAT);
    check_range("concurrency result", 128, 221);

    // errors
    apb_read(12'h420, rd, err);
    check_slverr("unmapped read", 1'b1, err);
    apb_write(12'h7F0, 32'hDEAD_BEEF, err);
    check_slverr("unmapped write", 1'b1, err);
    reg_read("cfg before", reg_addr(1, OFS_CFG), cfg_before);
    apb_write(reg_addr(1, OFS_CFG), 32'd1, err);
    check_slverr("k below range", 1'b1, err);
    apb_write(reg_addr(1, OFS_CFG), 32'd17, err);
    check_slverr("k above range", 1'b1, err);
    apb_write(reg_addr(1, OFS_CFG), 32'h0000_0205, err);
    check_slverr("reserved cfg bit", 1'b1, err);
    reg_read("cfg after", reg_addr(1, OFS_CFG), rd);
    check_word("cfg after illegal k", cfg_before, rd);

    configure(0, 0, 64, 2, MOD_MERSENNE);
    reg_write("long start", reg_addr(0, OFS_CTRL), 32'd1);
    reg_read("busy status", reg_addr(0, OFS_CTRL), st0);
    check_status("busy status", 2'b01, st0[1:0]);
    apb_write(reg_addr(0, OFS_CFG), 32'd5, err);
    check_slverr("cfg write while busy", 1'b1, err);
    apb_write(reg_addr(0, OFS_BASE), 32'd9, err);
    check_slverr("base write while busy", 1'b1, err);
    apb_write(reg_addr(0, OFS_CTRL), 32'd1, err);
    check_slverr("start while busy", 1'b1, err);
    reg_read("cfg while busy", reg_addr(0, OFS_CFG), rd);
    check_word("cfg while busy", 32'd2, rd);
    reg_read("base while busy", reg_addr(0, OFS_BASE), rd);
    check_word("base while busy", 32'd0, rd);
    wait_idle(0);
    apply_model(0, 64, 2, MOD_MERSENNE);
    check_range("long job result", 0, 65);

    // edge operands and bit lengths
    for (int f = 0; f < 2; f++) begin
      for (int j = 0; j < 2; j++) begin
        kind = (f == 0) ? MOD_MERSENNE : MOD_FERMAT;
        k0   = (j == 0) ? `MR_K_MIN : `MR_K_MAX;
        fill_random(238, 249);
        load_edge(240, k0, kind);
        run_job("edge operands", f, 240, 8, k0, kind);
      end
    end

    // empty job
    configure(1, 240, 0, 7, MOD_MERSENNE);
    reg_write("count zero start", reg_addr(1, OFS_CTRL), 32'd1);
    wait_idle(1);
    reg_read("count zero status", reg_addr(1, OFS_CTRL), st1);
    check_status("count zero status", 2'b10, st1[1:0]);
    check_range("count zero memory", 238, 249);

    $display("Test OK");
    $finish;
  end

endmodule

// ==== hw/modred_apb_regs.sv ====
`timescale 1ns/1ns
`include "modred_params.svh"

module modred_apb_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [11:0]           paddr_i,
  input  modred_pkg::word_t     pwdata_i,
  output modred_pkg::word_t     prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output logic [`MR_ADDR_W-1:0] mem_addr_o,
  output modred_pkg::word_t     mem_wdata_o,
  input  logic                  mem_gnt_i,
  input  logic                  mem_rvalid_i,
  input  modred_pkg::word_t     mem_rdata_i,
  output logic                  eng0_start_o,
  output logic [4:0]            eng0_k_o,
  output modred_pkg::mod_kind_e eng0_kind_o,
  output logic [`MR_ADDR_W-1:0] eng0_base_o,
  output logic [8:0]            eng0_count_o,
  input  logic                  eng0_busy_i,
  output logic                  eng1_start_o,
  output logic [4:0]            eng1_k_o,
  output modred_pkg::mod_kind_e eng1_kind_o,
  output logic [`MR_ADDR_W-1:0] eng1_base_o,
  output logic [8:0]            eng1_count_o,
  input  logic                  eng1_busy_i
);
  import modred_pkg::*;

  localparam int         NUM_ENG   = `MR_NUM_REQ - 1;
  localparam logic [1:0] REG_CFG   = 2'd0;
  localparam logic [1:0] REG_BASE  = 2'd1;
  localparam logic [1:0] REG_COUNT = 2'd2;
  localparam logic [1:0] REG_CTRL  = 2'd3;

  typedef enum logic [1:0] {SETUP, WAIT_GNT, WAIT_DATA} apb_state_e;

  apb_state_e            state_q;
  apb_state_e            state_d;
  logic                  access;
  logic                  is_mem;
  logic                  is_reg;
  logic                  eng_sel;
  logic                  reg_err;
  logic                  reg_wr;
  logic [11:0]           reg_off;
  logic [11:0]           eng_idx;
  logic [1:0]            reg_sel;
  logic [4:0]            wr_k;
  word_t                 reg_rdata;
  logic [4:0]            k_q     [NUM_ENG];
  mod_kind_e             kind_q  [NUM_ENG];
  logic [`MR_ADDR_W-1:0] base_q  [NUM_ENG];
  logic [8:0]            count_q [NUM_ENG];
  logic [NUM_ENG-1:0]    done_q;
  logic [NUM_ENG-1:0]    busy_q;
  logic [NUM_ENG-1:0]    busy;
  logic [NUM_ENG-1:0]    start;

  // ==========================================================
  // address decode and error check
  // ==========================================================
  assign access  = psel_i & penable_i;
  assign reg_off = paddr_i - 12'(`MR_REG_BASE);
  assign eng_idx = reg_off / 12'(`MR_ENG_STRIDE);
  assign is_mem  = paddr_i < 12'(`MR_REG_BASE);
  assign is_reg  = !is_mem && (eng_idx < 12'(NUM_ENG));
  assign eng_sel = eng_idx[0];
  assign reg_sel = reg_off[3:2];
  assign wr_k    = pwdata_i[4:0];
  assign busy    = {eng1_busy_i, eng0_busy_i};

  always_comb begin
    reg_err = 1'b0;
    if (!is_reg) begin
      reg_err = 1'b1;  // unmapped
    end else if (pwrite_i && busy[eng_sel]) begin
      reg_err = 1'b1;
    end else if (pwrite_i && reg_sel == REG_CFG) begin
      reg_err = (wr_k < 5'(`MR_K_MIN)) || (wr_k > 5'(`MR_K_MAX)) ||
                (|pwdata_i[`MR_DATA_W-1:9]) || (|pwdata_i[7:5]);
    end
  end

  assign reg_wr = access && !is_mem && pwrite_i && !reg_err;

  always_comb begin
    for (int e = 0; e < NUM_ENG; e++) begin
      start[e] = reg_wr && (reg_sel == REG_CTRL) && pwdata_i[0] && (eng_sel == 1'(e));
    end
  end

  always_comb begin
    reg_rdata = '0;
    if (is_reg) begin
      case (reg_sel)
        REG_CFG:   reg_rdata = word_t'({kind_q[eng_sel], 3'd0, k_q[eng_sel]});
        REG_BASE:  reg_rdata = word_t'(base_q[eng_sel]);
        REG_COUNT: reg_rdata = word_t'(count_q[eng_sel]);
        default:   reg_rdata = word_t'({done_q[eng_sel] | (busy_q[eng_sel] & !busy[eng_sel]),
                                        busy[eng_sel]});  // done shows as busy falls
      endcase
    end
  end

  // ==========================================================
  // access tracker, memory window stretches the access phase
  // ==========================================================
  always_comb begin
    state_d   = state_q;
    pready_o  = 1'b0;
    pslverr_o = 1'b0;
    prdata_o  = '0;
    mem_req_o = 1'b0;
    if (access && !is_mem) begin
      pready_o  = 1'b1;
      pslverr_o = reg_err;
      prdata_o  = pwrite_i ? '0 : reg_rdata;
    end else if (access) begin
      case (state_q)
        SETUP, WAIT_GNT: begin
          mem_req_o = 1'b1;
          if (mem_gnt_i) begin
            pready_o = pwrite_i;  // write lands at this edge
            state_d  = pwrite_i ? SETUP : WAIT_DATA;
          end else begin
            state_d = WAIT_GNT;
          end
        end
        WAIT_DATA: begin
          pready_o = mem_rvalid_i;
          prdata_o = mem_rdata_i;
          if (mem_rvalid_i) begin
            state_d = SETUP;
          end
        end
        default: begin
          state_d = SETUP;
        end
      endcase
    end
  end

  assign mem_we_o    = pwrite_i;
  assign mem_addr_o  = paddr_i[`MR_ADDR_W+1:2];
  assign mem_wdata_o = pwdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SETUP;
      busy_q  <= '0;
      done_q  <= '0;
      for (int e = 0; e < NUM_ENG; e++) begin
        k_q[e]     <= '0;
        kind_q[e]  <= MOD_MERSENNE;
        base_q[e]  <= '0;
        count_q[e] <= '0;
      end
    end else begin
      state_q <= state_d;
      busy_q  <= busy;
      for (int e = 0; e < NUM_ENG; e++) begin
        if (start[e]) begin
          done_q[e] <= 1'b0;
        end else if (busy_q[e] && !busy[e]) begin
          done_q[e] <= 1'b1;  // sticky until next start
        end
        if (reg_wr && eng_sel == 1'(e)) begin
          case (reg_sel)
            REG_CFG: begin
              k_q[e]    <= wr_k;
              kind_q[e] <= mod_kind_e'(pwdata_i[8]);
            end
            REG_BASE:  base_q[e]  <= pwdata_i[`MR_ADDR_W-1:0];
            REG_COUNT: count_q[e] <= pwdata_i[8:0];
            default: begin
            end
          endcase
        end
      end
    end
  end

  assign eng0_start_o = start[0];
  assign eng0_k_o     = k_q[0];
  assign eng0_kind_o  = kind_q[0];
  assign eng0_base_o  = base_q[0];
  assign eng0_count_o = count_q[0];
  assign eng1_start_o = start[1];
  assign eng1_k_o     = k_q[1];
  assign eng1_kind_o  = kind_q[1];
  assign eng1_base_o  = base_q[1];
  assign eng1_count_o = count_q[1];

endmodule

// ==== hw/modred_engine.sv ====
`timescale 1ns/1ns
`include "modred_params.svh"

module modred_engine (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  logic [4:0]            k_i,
  input  modred_pkg::mod_kind_e kind_i,
  input  logic [`MR_ADDR_W-1:0] base_i,
  input  logic [8:0]            count_i,
  output logic                  busy_o,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output logic [`MR_ADDR_W-1:0] mem_addr_o,
  output modred_pkg::word_t     mem_wdata_o,
  input  logic                  mem_gnt_i,
  input  logic                  mem_rvalid_i,
  input  modred_pkg::word_t     mem_rdata_i
);
  import modred_pkg::*;

  localparam int ACC_W = `MR_DATA_W + 2;  // sign plus carry headroom

  eng_state_e              state_q;
  eng_state_e              state_d;
  logic [4:0]              k_q;
  mod_kind_e               kind_q;
  logic [`MR_ADDR_W-1:0]   addr_q;
  logic [8:0]              remain_q;
  logic [5:0]              pos_q;
  logic [5:0]              pos_next;
  logic                    neg_q;
  word_t                   shreg_q;
  word_t                   chunk_mask;
  word_t                   chunk;
  logic signed [ACC_W-1:0] acc_q;
  logic signed [ACC_W-1:0] chunk_ext;
  logic signed [ACC_W-1:0] pow_k;
  logic signed [ACC_W-1:0] mod_m;
  logic                    fold_last;
  logic                    acc_neg;
  logic                    acc_high;

  // ==========================================================
  // modulus and fold datapath
  // ==========================================================
  assign pow_k = ACC_W'(1) << k_q;
  assign mod_m = (kind_q == MOD_FERMAT) ? pow_k + ACC_W'(1) : pow_k - ACC_W'(1);

  assign chunk_mask = ~({`MR_DATA_W{1'b1}} << k_q);
  assign chunk      = shreg_q & chunk_mask;
  assign chunk_ext  = {{(ACC_W - `MR_DATA_W){1'b0}}, chunk};

  assign pos_next  = pos_q + 6'(k_q);
  assign fold_last = pos_next >= 6'(`MR_DATA_W);  // ceil(32/k) chunks

  assign acc_neg  = acc_q[ACC_W-1];
  assign acc_high = !acc_neg && (acc_q >= mod_m);

  // ==========================================================
  // FSM
  // ==========================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = (count_i == '0) ? DONE : FETCH;
        end
      end
      FETCH: begin
        if (mem_gnt_i) begin
          state_d = LOAD;
        end
      end
      LOAD: begin
        if (mem_rvalid_i) begin
          state_d = FOLD;
        end
      end
      FOLD: begin
        if (fold_last) begin
          state_d = ADJUST;
        end
      end
      ADJUST: begin
        if (!acc_neg && !acc_high) begin
          state_d = STORE;
        end
      end
      STORE: begin
        if (mem_gnt_i) begin
          state_d = (remain_q == 9'd1) ? DONE : FETCH;
        end
      end
      DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      k_q      <= '0;
      kind_q   <= MOD_MERSENNE;
      addr_q   <= '0;
      remain_q <= '0;
      pos_q    <= '0;
      neg_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && start_i) begin
        k_q      <= k_i;
        kind_q   <= kind_i;
        addr_q   <= base_i;
        remain_q <= count_i;
      end
      if (state_q == LOAD) begin
        pos_q <= '0;
        neg_q <= 1'b0;
      end
      if (state_q == FOLD) begin
        pos_q <= pos_next;
        if (kind_q == MOD_FERMAT) begin
          neg_q <= ~neg_q;  // 2^k = -1 mod 2^k+1
        end
      end
      if (state_q == STORE && mem_gnt_i) begin
        addr_q   <= addr_q + 1'b1;
        remain_q <= remain_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    case (state_q)
      LOAD: begin
        if (mem_rvalid_i) begin
          shreg_q <= mem_rdata_i;
          acc_q   <= '0;
        end
      end
      FOLD: begin
        shreg_q <= shreg_q >> k_q;
        acc_q   <= neg_q ? acc_q - chunk_ext : acc_q + chunk_ext;
      end
      ADJUST: begin
        if (acc_neg) begin
          acc_q <= acc_q + mod_m;
        end else if (acc_high) begin
          acc_q <= acc_q - mod_m;
        end
      end
      default: begin
      end
    endcase
  end

  assign busy_o      = (state_q != IDLE);
  assign mem_req_o   = (state_q == FETCH) || (state_q == STORE);
  assign mem_we_o    = (state_q == STORE);
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = acc_q[`MR_DATA_W-1:0];  // in 0..m-1 by now

endmodule

// ==== hw/modred_params.svh ====
`ifndef MODRED_PARAMS_SVH
`define MODRED_PARAMS_SVH

// ==========================================================
// datapath and memory
// ==========================================================
`define MR_DATA_W     32
`define MR_MEM_DEPTH  256
`define MR_ADDR_W     8
`define MR_NUM_REQ    3      // 0 = apb, 1/2 = engines

// legal bit lengths of the modulus
`define MR_K_MIN      2
`define MR_K_MAX      16

// ==========================================================
// apb byte address map
// ==========================================================
`define MR_REG_BASE   'h400
`define MR_ENG_STRIDE 'h10

`endif

// ==== hw/modred_pkg.sv ====
package modred_pkg;

  `include "modred_params.svh"

  typedef logic [`MR_DATA_W-1:0] word_t;

  // modulus form selected by CFG bit 8
  typedef enum logic {
    MOD_MERSENNE = 1'b0,  // 2^k - 1
    MOD_FERMAT   = 1'b1   // 2^k + 1
  } mod_kind_e;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    LOAD,
    FOLD,
    ADJUST,
    STORE,
    DONE
  } eng_state_e;

endpackage

// ==== hw/modred_shared_mem.sv ====
`timescale 1ns/1ns
`include "modred_params.svh"

module modred_shared_mem (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic [`MR_NUM_REQ-1:0]                 req_i,
  input  logic [`MR_NUM_REQ-1:0]                 we_i,
  input  logic [`MR_NUM_REQ-1:0][`MR_ADDR_W-1:0] addr_i,
  input  modred_pkg::word_t [`MR_NUM_REQ-1:0]    wdata_i,
  output logic [`MR_NUM_REQ-1:0]                 gnt_o,
  output modred_pkg::word_t                      rdata_o,
  output logic [`MR_NUM_REQ-1:0]                 rvalid_o
);
  import modred_pkg::*;

  localparam int IDX_W = $clog2(`MR_NUM_REQ);

  logic [IDX_W-1:0]       rr_ptr_q;
  logic [IDX_W-1:0]       win_idx;
  logic                   any_gnt;
  word_t                  mem_q [`MR_MEM_DEPTH];
  word_t                  rdata_q;
  logic [`MR_NUM_REQ-1:0] rvalid_q;

  // ==========================================================
  // round-robin pick, starting at the pointer
  // ==========================================================
  always_comb begin
    int cand;
    gnt_o   = '0;
    win_idx = rr_ptr_q;
    any_gnt = 1'b0;
    for (int i = 0; i < `MR_NUM_REQ; i++) begin
      cand = (int'(rr_ptr_q) + i) % `MR_NUM_REQ;
      if (!any_gnt && req_i[cand]) begin
        any_gnt = 1'b1;
        win_idx = IDX_W'(cand);
      end
    end
    if (any_gnt) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_ptr_q <= '0;
      rvalid_q <= '0;
    end else begin
      if (any_gnt) begin
        // next search starts just past the winner
        rr_ptr_q <= (win_idx == IDX_W'(`MR_NUM_REQ - 1)) ? '0 : win_idx + 1'b1;
      end
      rvalid_q <= (any_gnt && !we_i[win_idx]) ? gnt_o : '0;  // tag with last winner
    end
  end

  // ==========================================================
  // word array, single port
  // ==========================================================
  always_ff @(posedge clk_i) begin
    if (any_gnt) begin
      if (we_i[win_idx]) begin
        mem_q[addr_i[win_idx]] <= wdata_i[win_idx];
      end else begin
        rdata_q <= mem_q[addr_i[win_idx]];
      end
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

endmodule

// ==== hw/modred_top.sv ====
`timescale 1ns/1ns
`include "modred_params.svh"

module modred_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [11:0]       paddr_i,
  input  modred_pkg::word_t pwdata_i,
  output modred_pkg::word_t prdata_o,
  output logic              pready_o,
  output logic              pslverr_o
);
  import modred_pkg::*;

  // requester 0 is apb, 1 and 2 the engines
  logic [`MR_NUM_REQ-1:0]                 req;
  logic [`MR_NUM_REQ-1:0]                 we;
  logic [`MR_NUM_REQ-1:0][`MR_ADDR_W-1:0] addr;
  word_t [`MR_NUM_REQ-1:0]                wdata;
  logic [`MR_NUM_REQ-1:0]                 gnt;
  logic [`MR_NUM_REQ-1:0]                 rvalid;
  word_t                                  rdata;

  logic                  eng_start [2];
  logic [4:0]            eng_k     [2];
  mod_kind_e             eng_kind  [2];
  logic [`MR_ADDR_W-1:0] eng_base  [2];
  logic [8:0]            eng_count [2];
  logic                  eng_busy  [2];

  modred_apb_regs u_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .mem_req_o    (req[0]),
    .mem_we_o     (we[0]),
    .mem_addr_o   (addr[0]),
    .mem_wdata_o  (wdata[0]),
    .mem_gnt_i    (gnt[0]),
    .mem_rvalid_i (rvalid[0]),
    .mem_rdata_i  (rdata),
    .eng0_start_o (eng_start[0]),
    .eng0_k_o     (eng_k[0]),
    .eng0_kind_o  (eng_kind[0]),
    .eng0_base_o  (eng_base[0]),
    .eng0_count_o (eng_count[0]),
    .eng0_busy_i  (eng_busy[0]),
    .eng1_start_o (eng_start[1]),
    .eng1_k_o     (eng_k[1]),
    .eng1_kind_o  (eng_kind[1]),
    .eng1_base_o  (eng_base[1]),
    .eng1_count_o (eng_count[1]),
    .eng1_busy_i  (eng_busy[1])
  );

  modred_engine u_eng0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (eng_start[0]),
    .k_i          (eng_k[0]),
    .kind_i       (eng_kind[0]),
    .base_i       (eng_base[0]),
    .count_i      (eng_count[0]),
    .busy_o       (eng_busy[0]),
    .mem_req_o    (req[1]),
    .mem_we_o     (we[1]),
    .mem_addr_o   (addr[1]),
    .mem_wdata_o  (wdata[1]),
    .mem_gnt_i    (gnt[1]),
    .mem_rvalid_i (rvalid[1]),
    .mem_rdata_i  (rdata)
  );

  modred_engine u_eng1 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (eng_start[1]),
    .k_i          (eng_k[1]),
    .kind_i       (eng_kind[1]),
    .base_i       (eng_base[1]),
    .count_i      (eng_count[1]),
    .busy_o       (eng_busy[1]),
    .mem_req_o    (req[2]),
    .mem_we_o     (we[2]),
    .mem_addr_o   (addr[2]),
    .mem_wdata_o  (wdata[2]),
    .mem_gnt_i    (gnt[2]),
    .mem_rvalid_i (rvalid[2]),
    .mem_rdata_i  (rdata)
  );

  modred_shared_mem u_mem (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (req),
    .we_i     (we),
    .addr_i   (addr),
    .wdata_i  (wdata),
    .gnt_o    (gnt),
    .rdata_o  (rdata),
    .rvalid_o (rvalid)
  );

endmodule

// ==== vlog.f ====
+incdir+hw
hw/modred_pkg.sv
hw/modred_shared_mem.sv
hw/modred_engine.sv
hw/modred_apb_regs.sv
hw/modred_top.sv
bench/modred_properties.sv
bench/modred_tb.sv
